/* tb.f */
src/blur_pkg.sv
src/line_buffer.sv
src/window_ctrl.sv
src/window_regs.sv
src/conv_pipe.sv
src/blur_filter.sv
verif/blur_asserts.sv
verif/tb_blur.sv

/* Makefile */
TOOL       := verilator
TOP        := tb_blur
FILELIST   := tb.f
FLAGS      := --binary --timing --assert -j 0 --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing -Wall --timescale 1ns/100ps
RUN_FLAGS  := +verilator+error+limit+100
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_blur.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_blur
    import blur_pkg::*;
();

    localparam int IMG_W       = 16;
    localparam int IMG_H       = 12;
    localparam int NPIX        = IMG_W * IMG_H;
    localparam int FLUSH_LEN   = 2 * IMG_W + 2;
    localparam int NUM_FRAMES  = 8;
    localparam int CYCLE_LIMIT = NUM_FRAMES * (NPIX * 4 + 2 * IMG_W + 100);

    // Blur kernels with weight sums 64 and 32
    localparam int K5 [5][5] = '{
        '{1, 2, 3, 2, 1},
        '{2, 3, 4, 3, 2},
        '{3, 4, 4, 4, 3},
        '{2, 3, 4, 3, 2},
        '{1, 2, 3, 2, 1}
    };
    localparam int K3 [3][3] = '{
        '{3, 4, 3},
        '{4, 4, 4},
        '{3, 4, 3}
    };

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    beat_t in_beat;
    logic  in_ready;
    mode_e mode;
    logic  out_valid;
    beat_t out_beat;

    logic [31:0] lfsr;
    pixel_t      frame_pix [NPIX];
    beat_t       got_q [$];
    int          cycle_count;
    int          pixel_errors;
    int          flag_errors;
    int          count_errors;
    int          assert_errors;

    blur_filter #(
        .IMG_WIDTH  (IMG_W),
        .IMG_HEIGHT (IMG_H)
    ) blur_filter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .mode      (mode),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // Zero padding outside the frame
    function automatic int pix_at(input int r, input int c);
        if (r < 0 || r >= IMG_H || c < 0 || c >= IMG_W) begin
            return 0;
        end
        return int'(frame_pix[r * IMG_W + c]);
    endfunction

    // Expected output pixel at row r, column c
    function automatic pixel_t model_pixel(input mode_e m, input int r, input int c);
        int     acc;
        pixel_t res;
        acc = 0;
        if (m == MODE_5X5) begin
            for (int dr = 0; dr < 5; dr++) begin
                for (int dc = 0; dc < 5; dc++) begin
                    acc += K5[dr][dc] * pix_at(r + dr - 2, c + dc - 2);
                end
            end
            res = pixel_t'(acc >> 6);
        end else if (m == MODE_3X3) begin
            for (int dr = 0; dr < 3; dr++) begin
                for (int dc = 0; dc < 3; dc++) begin
                    acc += K3[dr][dc] * pix_at(r + dr - 1, c + dc - 1);
                end
            end
            res = pixel_t'(acc >> 5);
        end else begin
            res = frame_pix[r * IMG_W + c];
        end
        return res;
    endfunction

    task automatic check_pixel(input int idx, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            pixel_errors++;
            $display("CHECK FAILED out_beat.data[%0d]: got %h expected %h", idx, got, exp);
        end
    endtask

    task automatic check_flags(input int idx, input beat_t got, input logic exp_sop,
                               input logic exp_eop);
        if (got.sop !== exp_sop || got.eop !== exp_eop) begin
            flag_errors++;
            $display("CHECK FAILED out_beat.sop/eop[%0d]: got %h expected %h",
                     idx, {got.sop, got.eop}, {exp_sop, exp_eop});
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < NPIX; i++) begin
            frame_pix[i] = pixel_t'(rand_bits(PIX_W));
        end
    endtask

    task automatic fill_const(input pixel_t value);
        for (int i = 0; i < NPIX; i++) begin
            frame_pix[i] = value;
        end
    endtask

    // Drive one frame and wait out the flush and the output beats
    task automatic send_frame(input mode_e m, input bit gaps, input bit switch_mode,
                              input mode_e next_m);
        int gap;
        int low_cycles;
        got_q.delete();
        while (!in_ready) begin
            @(posedge clk);
        end
        for (int i = 0; i < NPIX; i++) begin
            if (gaps) begin
                gap = int'(rand_bits(2));
                repeat (gap) begin
                    in_valid <= 1'b0;
                    @(posedge clk);
                end
            end
            in_valid <= 1'b1;
            in_beat  <= '{data: frame_pix[i], sop: (i == 0), eop: (i == NPIX - 1)};
            // Mode goes with the sop and a later change lands mid-frame
            if (i == 0) begin
                mode <= m;
            end else if (switch_mode && i == NPIX / 2) begin
                mode <= next_m;
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
        in_beat  <= '0;
        // Ready is low for the whole flush
        low_cycles = 0;
        @(negedge clk);
        while (!in_ready) begin
            low_cycles++;
            @(negedge clk);
        end
        check_count("in_ready low cycles after eop", low_cycles, FLUSH_LEN);
        while (got_q.size() < NPIX) begin
            @(negedge clk);
        end
        // Catch stray beats past the end of the frame
        repeat (8) @(negedge clk);
        @(posedge clk);
        check_count("output beats per frame", got_q.size(), NPIX);
    endtask

    task automatic check_frame(input mode_e m);
        int n;
        n = (got_q.size() < NPIX) ? got_q.size() : NPIX;
        for (int k = 0; k < n; k++) begin
            check_pixel(k, got_q[k].data, model_pixel(m, k / IMG_W, k % IMG_W));
            check_flags(k, got_q[k], k == 0, k == NPIX - 1);
        end
    endtask

    task automatic test_pass_through();
        fill_random();
        send_frame(MODE_PASS, 1'b1, 1'b0, MODE_PASS);
        check_frame(MODE_PASS);
    endtask

    task automatic test_blur3();
        fill_random();
        send_frame(MODE_3X3, 1'b1, 1'b0, MODE_3X3);
        check_frame(MODE_3X3);
    endtask

    task automatic test_blur5();
        fill_random();
        send_frame(MODE_5X5, 1'b0, 1'b0, MODE_5X5);
        check_frame(MODE_5X5);
        // Full scale everywhere gives the largest sums
        fill_const('1);
        send_frame(MODE_5X5, 1'b1, 1'b0, MODE_5X5);
        check_frame(MODE_5X5);
    endtask

    // Same pixels sent with and without valid gaps
    task automatic test_framing();
        fill_random();
        send_frame(MODE_3X3, 1'b1, 1'b0, MODE_3X3);
        check_frame(MODE_3X3);
        send_frame(MODE_3X3, 1'b0, 1'b0, MODE_3X3);
        check_frame(MODE_3X3);
    endtask

    task automatic test_mode_latch();
        fill_random();
        send_frame(MODE_3X3, 1'b1, 1'b1, MODE_5X5);
        check_frame(MODE_3X3);
        fill_random();
        send_frame(MODE_5X5, 1'b1, 1'b0, MODE_5X5);
        check_frame(MODE_5X5);
    endtask

    // Output collector samples away from the rising edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            got_q.push_back(out_beat);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        lfsr         = 32'h850034d4;
        cycle_count  = 0;
        pixel_errors = 0;
        flag_errors  = 0;
        count_errors = 0;
        rst_n        = 1'b1;
        in_valid     = 1'b0;
        in_beat      = '0;
        mode         = MODE_PASS;
        // Clean falling edge on rst_n
        #1;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_pass_through();
        test_blur3();
        test_blur5();
        test_framing();
        test_mode_latch();
        assert_errors = blur_filter_inst.blur_asserts_inst.fail_count;
        $display("Errors: pixel %0d, flags %0d, count %0d, assertions %0d",
                 pixel_errors, flag_errors, count_errors, assert_errors);
        if (pixel_errors + flag_errors + count_errors + assert_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/blur_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module blur_asserts
    import blur_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  in_valid,
    input logic  in_ready,
    input logic  out_valid,
    input beat_t out_beat
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Output strobes stay low while reset is held
    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!out_valid && !out_beat.sop && !out_beat.eop))
        else begin
            $error("out_valid or out_beat flags high during reset");
            fail_count++;
        end

    // Source presents beats only while the filter is ready
    accept_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> in_ready)
        else begin
            $error("in_valid high while in_ready is low");
            fail_count++;
        end

    // Start of frame always rides on a valid beat
    sop_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_beat.sop |-> out_valid)
        else begin
            $error("out_beat.sop high without out_valid");
            fail_count++;
        end

endmodule

bind blur_filter blur_asserts blur_asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat)
);

`default_nettype wire

/* src/blur_filter.sv */
`timescale 1ns/100ps
`default_nettype none

module blur_filter
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 12
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  beat_t in_beat,
    output logic  in_ready,
    input  mode_e mode,
    output logic  out_valid,
    output beat_t out_beat
);

    // Advance for the line buffer, and its one-cycle delayed copy for window_regs
    logic    advance;
    logic    shift;
    logic    flush;
    pixel_t  pixel;
    mask_t   win_mask;
    logic    emit;
    logic    emit_sop;
    logic    emit_eop;
    mode_e   cur_mode;
    column_t column;
    window_t window;
    logic    win_valid;

    // Accepted beats and flush beats share one stream
    assign advance = (in_valid & in_ready) | flush;
    // Flush beats carry zero
    assign pixel   = flush ? '0 : in_beat.data;

    window_ctrl #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) window_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .mode     (mode),
        .in_ready (in_ready),
        .advance  (shift),
        .flush    (flush),
        .win_mask (win_mask),
        .emit     (emit),
        .emit_sop (emit_sop),
        .emit_eop (emit_eop),
        .cur_mode (cur_mode)
    );

    line_buffer #(
        .IMG_WIDTH (IMG_WIDTH)
    ) line_buffer_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .pixel   (pixel),
        .column  (column)
    );

    window_regs window_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift),
        .column    (column),
        .win_mask  (win_mask),
        .emit      (emit),
        .window    (window),
        .win_valid (win_valid)
    );

    conv_pipe conv_pipe_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .window    (window),
        .cur_mode  (cur_mode),
        .emit_sop  (emit_sop),
        .emit_eop  (emit_eop),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

endmodule

`default_nettype wire

/* src/conv_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_pipe
    import blur_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    win_valid,
    input  window_t window,
    input  mode_e   cur_mode,
    input  logic    emit_sop,
    input  logic    emit_eop,
    output logic    out_valid,
    output beat_t   out_beat
);

    // Product and sum widths sized for full-scale pixels
    localparam int PROD_W = PIX_W + 3;
    localparam int ROW5_W = PIX_W + 5;
    localparam int ROW3_W = PIX_W + 4;
    localparam int TOT5_W = PIX_W + 6;
    localparam int TOT3_W = PIX_W + 5;

    // 5x5 weights by row then column, sum 64
    // Inner 3x3 gives 3 4 3 / 4 4 4 / 3 4 3, sum 32
    localparam logic [2:0] WEIGHT [5][5] = '{
        '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1},
        '{3'd2, 3'd3, 3'd4, 3'd3, 3'd2},
        '{3'd3, 3'd4, 3'd4, 3'd4, 3'd3},
        '{3'd2, 3'd3, 3'd4, 3'd3, 3'd2},
        '{3'd1, 3'd2, 3'd3, 3'd2, 3'd1}
    };

    // Flags riding beside the data
    typedef struct packed {
        logic  valid;
        logic  sop;
        logic  eop;
        mode_e mode;
    } tag_t;

    tag_t tag_in;
    tag_t tag_q [KERNEL_LAT];

    logic [PROD_W-1:0] prod_q [5][5];
    logic [ROW5_W-1:0] row5_d [5];
    logic [ROW5_W-1:0] row5_q [5];
    logic [ROW3_W-1:0] row3_d [3];
    logic [ROW3_W-1:0] row3_q [3];
    logic [TOT5_W-1:0] tot5_d;
    logic [TOT5_W-1:0] tot5_q;
    logic [TOT3_W-1:0] tot3_d;
    logic [TOT3_W-1:0] tot3_q;
    pixel_t            centre_q [3];
    pixel_t            data_q;

    assign tag_in = '{valid: win_valid, sop: emit_sop, eop: emit_eop, mode: cur_mode};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < KERNEL_LAT; k++) begin
                tag_q[k] <= '0;
            end
        end else begin
            tag_q[0] <= tag_in;
            for (int k = 1; k < KERNEL_LAT; k++) begin
                tag_q[k] <= tag_q[k-1];
            end
        end
    end

    // Row sums, full 5x5 and inner 3x3 (rows 1 to 3, columns 1 to 3)
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            row5_d[i] = '0;
            for (int j = 0; j < 5; j++) begin
                row5_d[i] = row5_d[i] + ROW5_W'(prod_q[i][j]);
            end
        end
        for (int i = 0; i < 3; i++) begin
            row3_d[i] = '0;
            for (int j = 1; j < 4; j++) begin
                row3_d[i] = row3_d[i] + ROW3_W'(prod_q[i+1][j]);
            end
        end
    end

    // Window totals
    always_comb begin
        tot5_d = '0;
        for (int i = 0; i < 5; i++) begin
            tot5_d = tot5_d + TOT5_W'(row5_q[i]);
        end
        tot3_d = '0;
        for (int i = 0; i < 3; i++) begin
            tot3_d = tot3_d + TOT3_W'(row3_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        // Stage 1, weighted products, window indexed by column then row
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                prod_q[i][j] <= PROD_W'(window[j][i]) * PROD_W'(WEIGHT[i][j]);
            end
        end
        centre_q[0] <= window[2][2];
        // Stage 2
        row5_q      <= row5_d;
        row3_q      <= row3_d;
        centre_q[1] <= centre_q[0];
        // Stage 3
        tot5_q      <= tot5_d;
        tot3_q      <= tot3_d;
        centre_q[2] <= centre_q[1];
        // Stage 4, normalize by the weight sum and pick by mode
        case (tag_q[2].mode)
            MODE_5X5: data_q <= tot5_q[TOT5_W-1:6];
            MODE_3X3: data_q <= tot3_q[TOT3_W-1:5];
            default:  data_q <= centre_q[2];
        endcase
    end

    assign out_valid = tag_q[KERNEL_LAT-1].valid;
    assign out_beat  = '{data: data_q,
                         sop:  tag_q[KERNEL_LAT-1].sop,
                         eop:  tag_q[KERNEL_LAT-1].eop};

endmodule

`default_nettype wire

/* src/window_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module window_regs
    import blur_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    shift,
    input  column_t column,
    input  mask_t   win_mask,
    input  logic    emit,
    output window_t window,
    output logic    win_valid
);

    // Last five columns, oldest in element 0
    window_t cols;
    window_t cols_next;
    window_t masked;

    // Drop the leftmost column and append the new one on the right
    assign cols_next = {column, cols[4:1]};

    // Zero every pixel whose row or column lies outside the frame
    always_comb begin
        for (int j = 0; j < 5; j++) begin
            for (int i = 0; i < 5; i++) begin
                if (win_mask.col_ok[j] && win_mask.row_ok[i]) begin
                    masked[j][i] = cols_next[j][i];
                end else begin
                    masked[j][i] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            cols <= cols_next;
        end
    end

    // Snapshot for the convolution on each emission
    always_ff @(posedge clk) begin
        if (emit) begin
            window <= masked;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= emit;
        end
    end

endmodule

`default_nettype wire

/* src/window_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module window_ctrl
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 12
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  beat_t in_beat,
    input  mode_e mode,
    output logic  in_ready,
    output logic  advance,
    output logic  flush,
    output mask_t win_mask,
    output logic  emit,
    output logic  emit_sop,
    output logic  emit_eop,
    output mode_e cur_mode
);

    localparam int COL_W     = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
    localparam int ROW_W     = $clog2(IMG_HEIGHT + 3);
    localparam int FLUSH_LEN = 2 * IMG_WIDTH + 2;
    localparam int FL_W      = $clog2(FLUSH_LEN);

    // Position of the current advance beat, rows run past the frame during flush
    logic [COL_W-1:0] in_col;
    logic [ROW_W-1:0] in_row;
    logic             flushing;
    logic [FL_W-1:0]  flush_cnt;
    mode_e            mode_lat;

    logic  accept;
    logic  adv;
    logic  flush_last;
    logic  started;
    int    ctr_col;
    int    ctr_row;
    mask_t mask_d;
    logic  sop_d;
    logic  eop_d;

    // First delay stage, aligned with the line buffer column
    logic  sop_a;
    logic  eop_a;
    mode_e mode_a;

    // Source is held off for the whole flush
    assign in_ready   = ~flushing;
    assign flush      = flushing;
    assign accept     = in_valid & in_ready;
    assign adv        = accept | flushing;
    assign flush_last = flushing && (flush_cnt == FL_W'(FLUSH_LEN - 1));

    // Centre is valid once 2*W+2 beats have gone in
    assign started = (in_row > ROW_W'(2)) ||
                     ((in_row == ROW_W'(2)) && (in_col >= COL_W'(2)));

    always_comb begin
        // Centre lags the advance position by two rows and two columns
        if (in_col >= COL_W'(2)) begin
            ctr_col = int'(in_col) - 2;
            ctr_row = int'(in_row) - 2;
        end else begin
            ctr_col = int'(in_col) + IMG_WIDTH - 2;
            ctr_row = int'(in_row) - 3;
        end
        // Window index k covers centre offset k-2
        for (int k = 0; k < 5; k++) begin
            mask_d.row_ok[k] = (ctr_row + k - 2 >= 0) && (ctr_row + k - 2 < IMG_HEIGHT);
            // Columns outside the row would wrap into a neighbouring row
            mask_d.col_ok[k] = (ctr_col + k - 2 >= 0) && (ctr_col + k - 2 < IMG_WIDTH);
        end
        sop_d = started && (ctr_row == 0) && (ctr_col == 0);
        eop_d = started && (ctr_row == IMG_HEIGHT - 1) && (ctr_col == IMG_WIDTH - 1);
    end

    // Frame counters, flush state and mode latch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_col    <= '0;
            in_row    <= '0;
            flushing  <= 1'b0;
            flush_cnt <= '0;
            mode_lat  <= MODE_PASS;
        end else begin
            if (accept && in_beat.sop) begin
                mode_lat <= mode;
            end
            if (accept && in_beat.eop) begin
                flushing <= 1'b1;
            end
            if (flush_last) begin
                // Last flush beat closes the frame
                flushing  <= 1'b0;
                flush_cnt <= '0;
                in_col    <= '0;
                in_row    <= '0;
            end else if (adv) begin
                if (flushing) begin
                    flush_cnt <= flush_cnt + 1'b1;
                end
                if (in_col == COL_W'(IMG_WIDTH - 1)) begin
                    in_col <= '0;
                    in_row <= in_row + 1'b1;
                end else begin
                    in_col <= in_col + 1'b1;
                end
            end
        end
    end

    // Strobes delayed to meet window_regs input, flags once more for its output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            advance  <= 1'b0;
            emit     <= 1'b0;
            sop_a    <= 1'b0;
            eop_a    <= 1'b0;
            mode_a   <= MODE_PASS;
            emit_sop <= 1'b0;
            emit_eop <= 1'b0;
            cur_mode <= MODE_PASS;
        end else begin
            advance  <= adv;
            emit     <= adv && started;
            sop_a    <= adv && sop_d;
            eop_a    <= adv && eop_d;
            mode_a   <= mode_lat;
            emit_sop <= sop_a;
            emit_eop <= eop_a;
            cur_mode <= mode_a;
        end
    end

    // Mask only matters alongside emit
    always_ff @(posedge clk) begin
        win_mask <= mask_d;
    end

endmodule

`default_nettype wire

/* src/line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer
    import blur_pkg::*;
#(
    parameter int IMG_WIDTH = 16
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    advance,
    input  pixel_t  pixel,
    output column_t column
);

    localparam int PTR_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;

    // Four row delays chained one after the other
    // Row 3 is one row above the incoming pixel, row 0 four rows above
    pixel_t row_mem [0:3][0:IMG_WIDTH-1];

    // Shared circular write pointer
    logic [PTR_W-1:0] wr_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (advance) begin
            // Wrap after the last column slot
            if (wr_ptr == PTR_W'(IMG_WIDTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Read the same slot in all rows, then push each value one row older
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int r = 0; r < 3; r++) begin
                row_mem[r][wr_ptr] <= row_mem[r+1][wr_ptr];
            end
            row_mem[3][wr_ptr] <= pixel;
            // Newest pixel lands in element 4
            column <= {pixel,
                       row_mem[3][wr_ptr],
                       row_mem[2][wr_ptr],
                       row_mem[1][wr_ptr],
                       row_mem[0][wr_ptr]};
        end
    end

endmodule

`default_nettype wire

/* src/blur_pkg.sv */
`default_nettype none

package blur_pkg;

    // Pixel width for every stream and window type
    localparam int PIX_W = 12;

    // Cycles from window strobe to output beat in the convolution pipeline
    localparam int KERNEL_LAT = 4;

    // One unsigned pixel
    typedef logic [PIX_W-1:0] pixel_t;

    // Filter operation
    // Unused code 3 behaves as pass-through
    typedef enum logic [1:0] {
        MODE_PASS = 2'd0,
        MODE_3X3  = 2'd1,
        MODE_5X5  = 2'd2
    } mode_e;

    // One stream beat
    // Valid is a separate strobe beside it
    typedef struct packed {
        pixel_t data;
        logic   sop;
        logic   eop;
    } beat_t;

    // Five vertically adjacent pixels
    // Element 0 sits two rows above the centre, element 4 is the newest row
    typedef pixel_t [4:0] column_t;

    // Five columns of the window, element 0 on the left
    typedef column_t [4:0] window_t;

    // In-frame flags per window row and column
    typedef struct packed {
        logic [4:0] row_ok;
        logic [4:0] col_ok;
    } mask_t;

endpackage

`default_nettype wire
